//--- hw/wbi_macros.svh
/* Bus widths and address map of the Wishbone interconnect
   Included by the package and by every module that decodes or sizes the bus */
`ifndef WBI_MACROS_SVH
`define WBI_MACROS_SVH

// Bus widths
`define WBI_DATA_W       32
`define WBI_ADDR_W       16
`define WBI_SEL_W        4

// MAC queue base, compared with address bits 15..6
`define WBI_QBASE_W      10
`define WBI_QBASE_LSB    6

// 256 byte register pages and 8 KB SRAM banks
`define WBI_PAGE_MSB     15
`define WBI_PAGE_LSB     8
`define WBI_BANK_LSB     13

// Host, MAC transmit DMA, MAC receive DMA
`define WBI_NUM_MASTERS  3

// --------------------
// Address map codes
// --------------------
`define WBI_PAGE_GLBL    8'h00
`define WBI_PAGE_MAC     8'h01
`define WBI_PAGE_MBIST0  8'h02
`define WBI_PAGE_MBIST1  8'h03
`define WBI_BANK_SRAMG0  3'd1
`define WBI_BANK_SRAMG1  3'd2

`endif

//--- hw/wbi_pkg.sv
/* Types shared by the interconnect modules and the testbench
   Request and response structs, target ids and arbiter states */
`include "wbi_macros.svh"

package wbi_pkg;

  // --------------------
  // Width types
  // --------------------
  typedef logic [`WBI_DATA_W-1:0]  wb_data_t;
  typedef logic [`WBI_ADDR_W-1:0]  wb_addr_t;
  typedef logic [`WBI_SEL_W-1:0]   wb_sel_t;
  typedef logic [`WBI_QBASE_W-1:0] qbase_t;

  // Master to slave direction
  typedef struct packed {
    wb_data_t dat;
    wb_addr_t adr;
    wb_sel_t  sel;
    logic     we;
    logic     cyc;
    logic     stb;
  } wb_req_t;

  // Slave to master direction
  typedef struct packed {
    wb_data_t dat;
    logic     ack;
  } wb_rsp_t;

  // Decoded destination of one master access
  typedef enum logic [2:0] {
    TGT_NULL,
    TGT_GLBL,
    TGT_MAC,
    TGT_SRAMG0,
    TGT_SRAMG1
  } target_id_t;

  // Shared port arbiter
  typedef enum logic {
    ARB_IDLE,
    ARB_BUSY
  } arb_state_t;

endpackage

//--- hw/wbi_addr_decode.sv
/* Address decoder for one master
   Clears the byte offset and maps the address to a target id */
`timescale 1ns/1ps
`include "wbi_macros.svh"

module wbi_addr_decode
  import wbi_pkg::*;
#(
  // Set for the DMA masters, which only see the SRAM banks
  parameter bit SRAM_ONLY = 1'b0
) (
  input  wb_req_t    req_i,
  output wb_req_t    req_o,
  output target_id_t tid_o
);

  localparam int PAGE_W = `WBI_PAGE_MSB - `WBI_PAGE_LSB + 1;
  localparam int BANK_W = `WBI_ADDR_W - `WBI_BANK_LSB;

  logic [PAGE_W-1:0] page;
  logic [BANK_W-1:0] bank;

  assign page = req_i.adr[`WBI_PAGE_MSB:`WBI_PAGE_LSB];
  assign bank = req_i.adr[`WBI_ADDR_W-1:`WBI_BANK_LSB];

  // Word aligned copy of the request
  always_comb begin
    req_o          = req_i;
    req_o.adr[1:0] = 2'b00;
  end

  // --------------------
  // Target map
  // --------------------
  always_comb begin
    tid_o = TGT_NULL;
    // SRAM banks first, open to every master
    if (bank == `WBI_BANK_SRAMG0) begin
      tid_o = TGT_SRAMG0;
    end else if (bank == `WBI_BANK_SRAMG1) begin
      tid_o = TGT_SRAMG1;
    end else if (!SRAM_ONLY) begin
      // Register pages, host only
      case (page)
        `WBI_PAGE_GLBL:   tid_o = TGT_GLBL;
        `WBI_PAGE_MAC:    tid_o = TGT_MAC;
        `WBI_PAGE_MBIST0: tid_o = TGT_SRAMG0;
        `WBI_PAGE_MBIST1: tid_o = TGT_SRAMG1;
        default:          tid_o = TGT_NULL;
      endcase
    end
  end

endmodule

//--- hw/wbi_stage_port.sv
/* Registered port from the host to one register slave
   Request and response both pass a flop stage to break the timing path */
`timescale 1ns/1ps

module wbi_stage_port
  import wbi_pkg::*;
(
  input  logic    clk_i,
  input  logic    reset_i,
  // Host side
  input  wb_req_t m_req_i,
  input  logic    m_sel_i,
  output wb_rsp_t m_rsp_o,
  // Slave side
  output wb_req_t s_req_o,
  input  wb_rsp_t s_rsp_i
);

  logic     pend_q;
  logic     ack_q;
  logic     accept;
  logic     s_done;
  wb_req_t  req_q;
  wb_data_t dat_q;

  // New access only when idle and not acking the last one
  assign accept = !pend_q && !ack_q && m_sel_i && m_req_i.cyc && m_req_i.stb;

  // Slave answered the staged request
  assign s_done = pend_q && s_rsp_i.ack;

  // --------------------
  // Control flops
  // --------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pend_q <= 1'b0;
      ack_q  <= 1'b0;
    end else begin
      // Master ack one cycle behind slave ack
      ack_q <= s_done;
      if (accept) begin
        pend_q <= 1'b1;
      end else if (s_done) begin
        pend_q <= 1'b0;
      end
    end
  end

  // --------------------
  // Payload flops
  // --------------------
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= m_req_i;
    end
    // Capture read data with the slave ack
    if (s_done) begin
      dat_q <= s_rsp_i.dat;
    end
  end

  // Strobe and cycle follow the pending flag
  always_comb begin
    s_req_o     = req_q;
    s_req_o.cyc = pend_q;
    s_req_o.stb = pend_q;
  end

  // Zero when not acking, so the top can OR responses
  always_comb begin
    m_rsp_o.dat = ack_q ? dat_q : '0;
    m_rsp_o.ack = ack_q;
  end

  // Once raised, slave stb is held until the slave acks
  a_stb_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (s_req_o.stb && !s_rsp_i.ack) |=> s_req_o.stb);

endmodule

//--- hw/wbi_shared_port.sv
/* Round-robin arbiter and multiplexer from all masters to one SRAM slave
   Grant is registered, then request and response pass through combinationally */
`timescale 1ns/1ps
`include "wbi_macros.svh"

module wbi_shared_port
  import wbi_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         reset_i,
  // Master side
  input  wb_req_t                      m_req_i [`WBI_NUM_MASTERS],
  input  logic [`WBI_NUM_MASTERS-1:0]  m_sel_i,
  output wb_rsp_t                      m_rsp_o [`WBI_NUM_MASTERS],
  // Slave side
  output wb_req_t                      s_req_o,
  input  wb_rsp_t                      s_rsp_i
);

  localparam int NUM_M  = `WBI_NUM_MASTERS;
  localparam int MIDX_W = $clog2(NUM_M);

  arb_state_t        state_q;
  logic [NUM_M-1:0]  grant_q;
  logic [MIDX_W-1:0] rr_ptr_q;
  logic [NUM_M-1:0]  req_vec;
  logic              pick_vld;
  logic [MIDX_W-1:0] pick_idx;
  logic [MIDX_W-1:0] pick_nxt;

  // Live requests aimed at this slave
  always_comb begin
    for (int i = 0; i < NUM_M; i++) begin
      req_vec[i] = m_sel_i[i] && m_req_i[i].cyc && m_req_i[i].stb;
    end
  end

  // --------------------
  // Round-robin pick
  // --------------------
  // Search starts at the pointer and wraps
  always_comb begin
    int unsigned idx;
    pick_vld = 1'b0;
    pick_idx = '0;
    for (int unsigned k = 0; k < NUM_M; k++) begin
      idx = (int'(rr_ptr_q) + k) % NUM_M;
      if (!pick_vld && req_vec[idx]) begin
        pick_vld = 1'b1;
        pick_idx = MIDX_W'(idx);
      end
    end
  end

  // Pointer moves past the winner
  assign pick_nxt = (pick_idx == MIDX_W'(NUM_M - 1)) ? '0 : pick_idx + 1'b1;

  // --------------------
  // Arbiter FSM
  // --------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q  <= ARB_IDLE;
      grant_q  <= '0;
      rr_ptr_q <= '0;
    end else begin
      case (state_q)
        ARB_IDLE: begin
          if (pick_vld) begin
            state_q  <= ARB_BUSY;
            grant_q  <= {{(NUM_M-1){1'b0}}, 1'b1} << pick_idx;
            rr_ptr_q <= pick_nxt;
          end
        end
        ARB_BUSY: begin
          // One idle cycle lets the finished master drop stb
          if (s_rsp_i.ack) begin
            state_q <= ARB_IDLE;
            grant_q <= '0;
          end
        end
        default: begin
          state_q <= ARB_IDLE;
          grant_q <= '0;
        end
      endcase
    end
  end

  // Granted request to the slave and all zero while idle
  always_comb begin
    s_req_o = '0;
    for (int i = 0; i < NUM_M; i++) begin
      if (grant_q[i]) begin
        s_req_o = m_req_i[i];
      end
    end
  end

  // Response only to the granted master and zero elsewhere for the OR in the top
  always_comb begin
    for (int i = 0; i < NUM_M; i++) begin
      m_rsp_o[i] = (grant_q[i] && s_rsp_i.ack) ? s_rsp_i : '0;
    end
  end

  // At most one master holds the grant
  a_grant_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(grant_q));

endmodule

//--- hw/wbi_qcnt_monitor.sv
/* MAC queue occupancy strobes
   Watches completed accesses on both SRAM ports against the queue bases */
`timescale 1ns/1ps
`include "wbi_macros.svh"

module wbi_qcnt_monitor
  import wbi_pkg::*;
(
  input  wb_req_t s2_req_i,
  input  wb_rsp_t s2_rsp_i,
  input  wb_req_t s3_req_i,
  input  wb_rsp_t s3_rsp_i,
  input  qbase_t  mac_tx_qbase_i,
  input  qbase_t  mac_rx_qbase_i,
  output logic    mac_tx_qcnt_inc_o,
  output logic    mac_tx_qcnt_dec_o,
  output logic    mac_rx_qcnt_inc_o,
  output logic    mac_rx_qcnt_dec_o
);

  // Completed access inside the queue window of this base
  function automatic logic q_hit(wb_req_t req, wb_rsp_t rsp, qbase_t base);
    return req.stb && rsp.ack && (req.adr[`WBI_ADDR_W-1:`WBI_QBASE_LSB] == base);
  endfunction

  // Write counts only when the top byte lane is written
  function automatic logic q_push(wb_req_t req);
    return req.we && req.sel[`WBI_SEL_W-1];
  endfunction

  // --------------------
  // Strobes
  // --------------------
  assign mac_tx_qcnt_inc_o =
      (q_hit(s2_req_i, s2_rsp_i, mac_tx_qbase_i) && q_push(s2_req_i)) ||
      (q_hit(s3_req_i, s3_rsp_i, mac_tx_qbase_i) && q_push(s3_req_i));
  assign mac_tx_qcnt_dec_o =
      (q_hit(s2_req_i, s2_rsp_i, mac_tx_qbase_i) && !s2_req_i.we) ||
      (q_hit(s3_req_i, s3_rsp_i, mac_tx_qbase_i) && !s3_req_i.we);
  assign mac_rx_qcnt_inc_o =
      (q_hit(s2_req_i, s2_rsp_i, mac_rx_qbase_i) && q_push(s2_req_i)) ||
      (q_hit(s3_req_i, s3_rsp_i, mac_rx_qbase_i) && q_push(s3_req_i));
  assign mac_rx_qcnt_dec_o =
      (q_hit(s2_req_i, s2_rsp_i, mac_rx_qbase_i) && !s2_req_i.we) ||
      (q_hit(s3_req_i, s3_rsp_i, mac_rx_qbase_i) && !s3_req_i.we);

endmodule

//--- hw/wbi_top.sv
/* Wishbone interconnect, three masters to four slaves
   Host reaches all slaves, the MAC DMA masters only the SRAM groups */
`timescale 1ns/1ps
`include "wbi_macros.svh"

module wbi_top
  import wbi_pkg::*;
(
  input  logic    clk_i,
  input  logic    reset_i,
  // Masters: host, MAC TX DMA, MAC RX DMA
  input  wb_req_t m0_req_i,
  input  wb_req_t m1_req_i,
  input  wb_req_t m2_req_i,
  output wb_rsp_t m0_rsp_o,
  output wb_rsp_t m1_rsp_o,
  output wb_rsp_t m2_rsp_o,
  // Slaves: global regs, MAC, SRAM group 0, SRAM group 1
  output wb_req_t s0_req_o,
  output wb_req_t s1_req_o,
  output wb_req_t s2_req_o,
  output wb_req_t s3_req_o,
  input  wb_rsp_t s0_rsp_i,
  input  wb_rsp_t s1_rsp_i,
  input  wb_rsp_t s2_rsp_i,
  input  wb_rsp_t s3_rsp_i,
  // MAC queue occupancy
  input  qbase_t  mac_tx_qbase_i,
  input  qbase_t  mac_rx_qbase_i,
  output logic    mac_tx_qcnt_inc_o,
  output logic    mac_tx_qcnt_dec_o,
  output logic    mac_rx_qcnt_inc_o,
  output logic    mac_rx_qcnt_dec_o
);

  localparam int NUM_M = `WBI_NUM_MASTERS;

  wb_req_t              m_req_raw [NUM_M];
  wb_req_t              m_req     [NUM_M];
  target_id_t           m_tid     [NUM_M];
  logic [NUM_M-1:0]     s2_sel;
  logic [NUM_M-1:0]     s3_sel;
  wb_rsp_t              s2_m_rsp  [NUM_M];
  wb_rsp_t              s3_m_rsp  [NUM_M];
  wb_rsp_t              s0_m_rsp;
  wb_rsp_t              s1_m_rsp;

  assign m_req_raw[0] = m0_req_i;
  assign m_req_raw[1] = m1_req_i;
  assign m_req_raw[2] = m2_req_i;

  // --------------------
  // Decode per master
  // --------------------
  for (genvar i = 0; i < NUM_M; i++) begin : g_dec
    // Only the host sees the register pages
    wbi_addr_decode #(.SRAM_ONLY(i != 0)) u_dec (
      .req_i (m_req_raw[i]),
      .req_o (m_req[i]),
      .tid_o (m_tid[i])
    );
    assign s2_sel[i] = (m_tid[i] == TGT_SRAMG0);
    assign s3_sel[i] = (m_tid[i] == TGT_SRAMG1);
  end

  // Staged register slaves, host only
  wbi_stage_port u_s0 (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .m_req_i (m_req[0]),
    .m_sel_i (m_tid[0] == TGT_GLBL),
    .m_rsp_o (s0_m_rsp),
    .s_req_o (s0_req_o),
    .s_rsp_i (s0_rsp_i)
  );

  wbi_stage_port u_s1 (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .m_req_i (m_req[0]),
    .m_sel_i (m_tid[0] == TGT_MAC),
    .m_rsp_o (s1_m_rsp),
    .s_req_o (s1_req_o),
    .s_rsp_i (s1_rsp_i)
  );

  // Arbitrated SRAM groups
  wbi_shared_port u_s2 (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .m_req_i (m_req),
    .m_sel_i (s2_sel),
    .m_rsp_o (s2_m_rsp),
    .s_req_o (s2_req_o),
    .s_rsp_i (s2_rsp_i)
  );

  wbi_shared_port u_s3 (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .m_req_i (m_req),
    .m_sel_i (s3_sel),
    .m_rsp_o (s3_m_rsp),
    .s_req_o (s3_req_o),
    .s_rsp_i (s3_rsp_i)
  );

  // One port answers a master at a time
  assign m0_rsp_o = s0_m_rsp | s1_m_rsp | s2_m_rsp[0] | s3_m_rsp[0];
  assign m1_rsp_o = s2_m_rsp[1] | s3_m_rsp[1];
  assign m2_rsp_o = s2_m_rsp[2] | s3_m_rsp[2];

  wbi_qcnt_monitor u_qcnt (
    .s2_req_i          (s2_req_o),
    .s2_rsp_i          (s2_rsp_i),
    .s3_req_i          (s3_req_o),
    .s3_rsp_i          (s3_rsp_i),
    .mac_tx_qbase_i    (mac_tx_qbase_i),
    .mac_rx_qbase_i    (mac_rx_qbase_i),
    .mac_tx_qcnt_inc_o (mac_tx_qcnt_inc_o),
    .mac_tx_qcnt_dec_o (mac_tx_qcnt_dec_o),
    .mac_rx_qcnt_inc_o (mac_rx_qcnt_inc_o),
    .mac_rx_qcnt_dec_o (mac_rx_qcnt_dec_o)
  );

endmodule

//--- dv/tb_wbi_slave_model.sv
/* Memory-backed Wishbone slave for the interconnect testbench
   Acks each request once, after a random wait of 0 to 3 extra cycles */
`timescale 1ns/1ps

module tb_wbi_slave_model
  import wbi_pkg::*;
(
  input  logic    clk_i,
  input  logic    reset_i,
  input  wb_req_t req_i,
  output wb_rsp_t rsp_o
);

  wb_data_t   mem [64];
  wb_data_t   rd_q;
  logic       ack_q;
  logic       busy_q;
  logic [1:0] wait_q;
  logic [5:0] idx;
  integer     seed = 48545;

  // Word index, 64 words are enough for the test addresses
  assign idx = req_i.adr[7:2];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_q  <= 1'b0;
      busy_q <= 1'b0;
      wait_q <= 2'd0;
    end else begin
      ack_q <= 1'b0;
      // No new request in the ack cycle
      if (req_i.cyc && req_i.stb && !ack_q) begin
        if (!busy_q) begin
          busy_q <= 1'b1;
          wait_q <= 2'($random(seed));
        end else if (wait_q != 2'd0) begin
          wait_q <= wait_q - 2'd1;
        end else begin
          busy_q <= 1'b0;
          ack_q  <= 1'b1;
          rd_q   <= mem[idx];
          // Byte lanes follow sel
          if (req_i.we) begin
            for (int b = 0; b < 4; b++) begin
              if (req_i.sel[b]) begin
                mem[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
              end
            end
          end
        end
      end
    end
  end

  assign rsp_o.dat = ack_q ? rd_q : '0;
  assign rsp_o.ack = ack_q;

endmodule

//--- dv/tb_wbi.sv
/* Testbench for the Wishbone interconnect
   Drives the three masters against four memory-backed slaves
   Concurrent assertions compare both bus sides with the address map */
`timescale 1ns/1ps

module tb_wbi
  import wbi_pkg::*;
();

  localparam int ACK_TIMEOUT = 64;

  logic       clk;
  logic       reset;
  wb_req_t    m_req [3];
  wb_rsp_t    m_rsp [3];
  wb_req_t    s_req [4];
  wb_rsp_t    s_rsp [4];
  qbase_t     qbase [2];
  logic [3:0] qcnt;
  logic [3:0] qcnt_exp;
  logic       any_stb;
  logic       any_ack;
  logic       probe_null;
  int         err_cnt;
  int         tmo_cnt;
  integer     seed;
  wb_data_t   rdat;
  wb_data_t   d [3];

  wbi_top u_wbi_top (
    .clk_i (clk), .reset_i (reset),
    .m0_req_i (m_req[0]), .m1_req_i (m_req[1]), .m2_req_i (m_req[2]),
    .m0_rsp_o (m_rsp[0]), .m1_rsp_o (m_rsp[1]), .m2_rsp_o (m_rsp[2]),
    .s0_req_o (s_req[0]), .s1_req_o (s_req[1]), .s2_req_o (s_req[2]), .s3_req_o (s_req[3]),
    .s0_rsp_i (s_rsp[0]), .s1_rsp_i (s_rsp[1]), .s2_rsp_i (s_rsp[2]), .s3_rsp_i (s_rsp[3]),
    .mac_tx_qbase_i (qbase[0]), .mac_rx_qbase_i (qbase[1]),
    .mac_tx_qcnt_inc_o (qcnt[3]), .mac_tx_qcnt_dec_o (qcnt[2]),
    .mac_rx_qcnt_inc_o (qcnt[1]), .mac_rx_qcnt_dec_o (qcnt[0])
  );

  for (genvar s = 0; s < 4; s++) begin : g_slv
    tb_wbi_slave_model u_slv (
      .clk_i (clk), .reset_i (reset), .req_i (s_req[s]), .rsp_o (s_rsp[s])
    );
  end

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Address map as seen from each slave
  function automatic bit slave_owns(int s, wb_addr_t a);
    case (s)
      0:       return a[15:8] == 8'h00;
      1:       return a[15:8] == 8'h01;
      2:       return a[15:13] == 3'd1 || a[15:8] == 8'h02;
      default: return a[15:13] == 3'd2 || a[15:8] == 8'h03;
    endcase
  endfunction

  // Queue strobes expected from the SRAM port traffic
  // Transmit strobes sit in bits 3..2 and receive strobes in bits 1..0
  always_comb begin
    qcnt_exp = '0;
    for (int s = 2; s < 4; s++) begin
      for (int q = 0; q < 2; q++) begin
        if (s_req[s].stb && s_rsp[s].ack && s_req[s].adr[15:6] == qbase[q]) begin
          if (s_req[s].we && s_req[s].sel[3]) qcnt_exp[3-2*q] = 1'b1;
          if (!s_req[s].we) qcnt_exp[2-2*q] = 1'b1;
        end
      end
    end
  end

  assign any_stb = s_req[0].stb | s_req[1].stb | s_req[2].stb | s_req[3].stb;
  assign any_ack = m_rsp[0].ack | m_rsp[1].ack | m_rsp[2].ack;

  // --------------------
  // Checks
  // --------------------
  for (genvar s = 0; s < 4; s++) begin : g_chk
    a_align: assert property (@(posedge clk) disable iff (reset)
      s_req[s].stb |-> s_req[s].adr[1:0] == 2'b00)
      else begin
        err_cnt++;
        $display("ERR %0t: s%0d address not word aligned", $time, s);
      end
    a_map: assert property (@(posedge clk) disable iff (reset)
      s_req[s].stb |-> slave_owns(s, s_req[s].adr))
      else begin
        err_cnt++;
        $display("ERR %0t: s%0d got address %h", $time, s, s_req[s].adr);
      end
    // Strobe low for a cycle between two accesses
    a_gap: assert property (@(posedge clk) disable iff (reset)
      (s_req[s].stb && s_rsp[s].ack) |=> !s_req[s].stb)
      else begin
        err_cnt++;
        $display("ERR %0t: s%0d stb held across accesses", $time, s);
      end
  end

  a_null: assert property (@(posedge clk) disable iff (reset)
    probe_null |-> (!any_stb && !m_rsp[1].ack))
    else begin
      err_cnt++;
      $display("ERR %0t: unmapped access was forwarded", $time);
    end

  a_qcnt: assert property (@(posedge clk) disable iff (reset) qcnt == qcnt_exp)
    else begin
      err_cnt++;
      $display("ERR %0t: qcnt %b, expected %b", $time, qcnt, qcnt_exp);
    end

  a_rst_idle: assert property (@(posedge clk) $past(reset) |-> (!any_stb && !any_ack))
    else begin
      err_cnt++;
      $display("ERR %0t: stb or ack high after reset", $time);
    end

  // --------------------
  // Master tasks
  // --------------------
  task automatic bus_xfer(input int m, input logic we, input wb_addr_t adr,
                          input wb_data_t dat, input wb_sel_t sel, input bit want_ack,
                          output wb_data_t got);
    int n;
    n   = 0;
    got = '0;
    @(posedge clk);
    #2;
    m_req[m].dat = we ? dat : '0;
    m_req[m].adr = adr;
    m_req[m].sel = sel;
    m_req[m].we  = we;
    m_req[m].cyc = 1'b1;
    m_req[m].stb = 1'b1;
    // Ack is stable at the falling edge
    @(negedge clk);
    while (!m_rsp[m].ack && n < ACK_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (m_rsp[m].ack) begin
      got = m_rsp[m].dat;
    end else if (want_ack) begin
      tmo_cnt++;
      $display("Timeout: master %0d got no ack for address %h", m, adr);
    end
    @(posedge clk);
    #2;
    m_req[m] = '0;
  endtask

  task automatic write_word(input int m, input wb_addr_t adr, input wb_data_t dat,
                            input wb_sel_t sel);
    wb_data_t unused;
    bus_xfer(m, 1'b1, adr, dat, sel, 1'b1, unused);
  endtask

  task automatic read_check(input int m, input wb_addr_t adr, input wb_data_t exp);
    wb_data_t got;
    bus_xfer(m, 1'b0, adr, '0, 4'hF, 1'b1, got);
    assert (got === exp) else begin
      err_cnt++;
      $display("ERR %0t: master %0d read %h at %h, expected %h", $time, m, got, adr, exp);
    end
  endtask

  initial begin
    reset      = 1'b1;
    probe_null = 1'b0;
    err_cnt    = 0;
    tmo_cnt    = 0;
    seed       = 48545;
    m_req[0]   = '0;
    m_req[1]   = '0;
    m_req[2]   = '0;
    // Queue windows at 0x2040 and 0x4000
    qbase[0]   = 10'h081;
    qbase[1]   = 10'h100;
    repeat (2) @(posedge clk);
    #2;
    reset = 1'b0;

    // Host to the staged register slaves at unaligned addresses
    write_word(0, 16'h0012, 32'hCAFE_0001, 4'hF);
    read_check(0, 16'h0012, 32'hCAFE_0001);
    write_word(0, 16'h0107, 32'hBEEF_0002, 4'hF);
    read_check(0, 16'h0107, 32'hBEEF_0002);

    // DMA masters in the SRAM banks and the queue windows
    write_word(1, 16'h2040, 32'h1122_3344, 4'hF);
    write_word(1, 16'h2040, 32'hAABB_CCDD, 4'h7);
    read_check(1, 16'h2040, 32'h11BB_CCDD);
    write_word(2, 16'h4010, 32'h5566_7788, 4'hF);
    read_check(2, 16'h4010, 32'h5566_7788);

    // Unmapped for a DMA master and never acked
    probe_null = 1'b1;
    bus_xfer(1, 1'b1, 16'h0100, 32'hDEAD_0000, 4'hF, 1'b0, rdat);
    probe_null = 1'b0;

    // Host through the MBIST pages at unaligned addresses
    write_word(0, 16'h020A, 32'h0202_0808, 4'hF);
    read_check(0, 16'h020A, 32'h0202_0808);
    write_word(0, 16'h0307, 32'h0303_0404, 4'hF);
    read_check(0, 16'h0307, 32'h0303_0404);

    // All masters on s2 in the same cycle
    for (int r = 0; r < 4; r++) begin
      d[0] = $random(seed);
      d[1] = $random(seed);
      d[2] = $random(seed);
      fork
        write_word(0, 16'h0240 + 16'(4*r), d[0], 4'hF);
        write_word(1, 16'h2080 + 16'(4*r), d[1], 4'hF);
        write_word(2, 16'h20C0 + 16'(4*r), d[2], 4'hF);
      join
      fork
        read_check(0, 16'h0240 + 16'(4*r), d[0]);
        read_check(1, 16'h2080 + 16'(4*r), d[1]);
        read_check(2, 16'h20C0 + 16'(4*r), d[2]);
      join
    end

    repeat (4) @(posedge clk);
    $display("Errors: %0d check, %0d timeout", err_cnt, tmo_cnt);
    if (err_cnt == 0 && tmo_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+hw
hw/wbi_pkg.sv
hw/wbi_addr_decode.sv
hw/wbi_stage_port.sv
hw/wbi_shared_port.sv
hw/wbi_qcnt_monitor.sv
hw/wbi_top.sv
dv/tb_wbi_slave_model.sv
dv/tb_wbi.sv

//--- run.sh
#!/bin/sh
# Build and run the interconnect testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f compile.f --top-module tb_wbi -Mdir "$OBJ" -o tb_wbi
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/tb_wbi" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '^>>> PASS$' "$LOG"; then
  exit 0
else
  echo "Pass message not found in $LOG"
  exit 1
fi
